// File: all.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/msg_source.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_msg_top.sv
testbench/tb_uart_msg.sv

// File: Makefile
# Verilator build and run for the serial message beacon.

SIM = obj_dir/Vtb_uart_msg

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

$(SIM): all.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f all.f \
	  --top-module tb_uart_msg -o Vtb_uart_msg

clean:
	rm -rf obj_dir

// File: testbench/tb_uart_msg.sv
/*
  Serial message beacon testbench.
  Random run level, serial line decoder and message model,
  checking byte order, framing, msg_done and pause behavior.
*/

`timescale 1ns/10ps

`include "uart_consts.svh"

module tb_uart_msg;

  localparam int clk_period   = 100;                                      // ns.
  localparam int frame_cycles = `UART_BITS_PER_FRAME * `UART_CLKS_PER_BIT;  // One frame.
  localparam int watchdog_cycles = 4 * `MSG_LEN * (frame_cycles + 1) * 2 + 2000;

  logic        clk;
  logic        arst_n;
  logic        run;
  logic        txd;
  logic        msg_done;

  logic        hold_low;    // Force run low.
  logic [15:0] lfsr;        // Random source state.
  logic [1:0]  draw;        // Two bits per window.
  logic [5:0]  win_cnt;     // 64 cycle window.
  string       msg_text = "Lorem Ipsum\r\n";   // Expected message.
  int          rx_idx;      // Model index of next byte.
  int          bytes_rx;    // Decoded bytes.
  int          lf_count;    // Decoded line feeds.
  int          done_count;  // msg_done pulses.
  int          errors;
  int          checks;
  logic [7:0]  last_byte;   // Most recent decoded byte.
  time         stop_t;      // Stop bit sample time.

  uart_msg_top dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .txd      (txd),
    .msg_done (msg_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 16 bit Fibonacci LFSR, taps 16 14 13 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
      begin
        errors++;
        $display("error: %s expected %0h got %0h at %0t", name, expected, actual, $time);
      end
  endtask

  task automatic count_fault(input string text);
    errors++;
    $display("%s at %0t", text, $time);
  endtask

  task automatic report_test(input string name, input int base);
    $display("test %s finished with %0d errors", name, errors - base);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, run stimulus, watchdog
  //////////////////////////////////////////////////////////////////////

  initial
    begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
    end

  // New run level every 64 cycles, low on a 00 draw.
  initial
    begin
      run     = 1'b0;
      lfsr    = 16'd4053;
      win_cnt = '0;
      forever
        begin
          @(posedge clk);
          if (hold_low)
            run <= 1'b0;
          else if (win_cnt == 6'd0)
            begin
              lfsr    = lfsr_step(lfsr);
              draw[0] = lfsr[0];
              lfsr    = lfsr_step(lfsr);
              draw[1] = lfsr[0];
              run <= (draw != 2'b00);
            end
          win_cnt = win_cnt + 1'b1;
        end
    end

  initial
    begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: fewer than 4 messages after %0d cycles", watchdog_cycles);
      $display("Test failed");
      $finish;
    end

  //////////////////////////////////////////////////////////////////////
  // Line decoder and model
  //////////////////////////////////////////////////////////////////////

  initial
    begin : line_decoder
      logic [7:0] rx;
      time        edge_t;
      time        last_edge_t;
      bit         have_edge;
      have_edge = 1'b0;
      wait (arst_n === 1'b1);
      forever
        begin
          @(negedge txd);   // Start edge.
          edge_t = $time;
          if (have_edge && (edge_t - last_edge_t) < (frame_cycles + 1) * clk_period)
            count_fault("start edges closer than one frame plus one cycle");
          have_edge   = 1'b1;
          last_edge_t = edge_t;
          check_value("msg_done_count", 32'(lf_count), 32'(done_count));
          repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);   // Mid start bit.
          check_value("start_bit", 32'd0, 32'(txd));
          for (int i = 0; i < 8; i++)
            begin
              repeat (`UART_CLKS_PER_BIT) @(negedge clk);
              rx[i] = txd;   // LSB first.
            end
          repeat (`UART_CLKS_PER_BIT) @(negedge clk);
          check_value("stop_bit", 32'd1, 32'(txd));
          stop_t = $time;
          check_value("rx_byte", 32'(msg_text[rx_idx]), 32'(rx));
          last_byte = rx;
          if (rx == 8'h0a)
            lf_count++;
          rx_idx = (rx_idx + 1) % `MSG_LEN;
          bytes_rx++;
        end
    end

  // msg_done must sit in the last cycle of a line feed stop bit.
  initial
    forever
      begin
        @(negedge clk);
        if (arst_n && msg_done)
          begin
            done_count++;
            check_value("msg_done_byte", 32'h0a, 32'(last_byte));
            check_value("msg_done_count", 32'(lf_count), 32'(done_count));
            check_value("msg_done_delay", 32'(`UART_CLKS_PER_BIT / 2),
                        32'(($time - stop_t) / clk_period));
          end
      end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
    begin : main
      int base;
      int quiet;
      int paused_bytes;
      arst_n   = 1'b0;
      hold_low = 1'b1;
      check_value("msg_len", 32'(`MSG_LEN), 32'(msg_text.len()));

      // Idle after reset.
      base = errors;
      repeat (5)
        begin
          @(negedge clk);
          check_value("txd", 32'd1, 32'(txd));
          check_value("msg_done", 32'd0, 32'(msg_done));
        end
      @(posedge clk);
      arst_n <= 1'b1;
      repeat (8)
        begin
          @(negedge clk);
          check_value("txd", 32'd1, 32'(txd));
          check_value("msg_done", 32'd0, 32'(msg_done));
        end
      report_test("idle_after_reset", base);

      // Random run, two messages under back pressure.
      base     = errors;
      hold_low = 1'b0;
      while (lf_count < 2)
        @(negedge clk);
      report_test("stream", base);

      // Pause until the FIFO drains and the line stays high.
      base     = errors;
      hold_low = 1'b1;
      quiet    = 0;
      while (quiet < 2 * frame_cycles)
        begin
          @(negedge clk);
          quiet = txd ? quiet + 1 : 0;
        end
      paused_bytes = bytes_rx;
      repeat (2 * frame_cycles)
        begin
          @(negedge clk);
          check_value("txd", 32'd1, 32'(txd));   // Paused source sends nothing.
        end
      check_value("bytes_rx", 32'(paused_bytes), 32'(bytes_rx));
      report_test("pause", base);

      // Resume, stream must continue at the next character.
      base     = errors;
      hold_low = 1'b0;
      while (lf_count < 4)
        @(negedge clk);
      repeat (`UART_CLKS_PER_BIT) @(negedge clk);   // Let last msg_done land.
      check_value("msg_done_total", 32'(lf_count), 32'(done_count));
      report_test("resume", base);

      $display("%0d checks, %0d errors, %0d bytes, %0d messages",
               checks, errors, bytes_rx, lf_count);
      if (errors == 0)
        $display("Test passed");
      else
        $display("Test failed");
      $finish;
    end

endmodule

// File: verilog/uart_msg_top.sv
/*
  Serial message beacon top.
  Message source feeding a byte FIFO drained by an 8N1 transmitter.
*/

`timescale 1ns/10ps

module uart_msg_top (
  input  logic clk,        // Clock.
  input  logic arst_n,     // Async reset, active low.
  input  logic run,        // Let the source fetch characters.
  output logic txd,        // Serial line.
  output logic msg_done    // Pulse per completed message.
);

  import uart_pkg::*;

  logic      push;        // Source write strobe.
  logic      pop;         // Transmitter read strobe.
  logic      full;        // FIFO full, source busy.
  logic      empty;       // FIFO empty.
  msg_beat_t push_beat;   // Source to FIFO.
  msg_beat_t head_beat;   // FIFO to transmitter.

  //////////////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  //////////////////////////////////////////////////////////////////////

  msg_source u_source (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .busy      (full),   // Back pressure from FIFO.
    .push      (push),
    .push_beat (push_beat)
  );

  byte_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_beat (push_beat),
    .pop       (pop),
    .head_beat (head_beat),
    .full      (full),
    .empty     (empty)
  );

  uart_tx u_tx (
    .clk       (clk),
    .arst_n    (arst_n),
    .empty     (empty),
    .head_beat (head_beat),
    .pop       (pop),
    .txd       (txd),
    .msg_done  (msg_done)
  );

endmodule

// File: verilog/uart_tx.sv
/*
  UART transmitter.
  Pops byte beats from the FIFO and sends each as an 8N1 frame,
  flagging the stop bit of the last character of a message.
*/

`timescale 1ns/10ps

`include "uart_consts.svh"

module uart_tx (
  input  logic                clk,         // Clock.
  input  logic                arst_n,      // Async reset, active low.
  input  logic                empty,       // FIFO has no beat.
  input  uart_pkg::msg_beat_t head_beat,   // Oldest FIFO beat.
  output logic                pop,         // Take head beat.
  output logic                txd,         // Serial line.
  output logic                msg_done     // End of message pulse.
);

  import uart_pkg::*;

  localparam int data_bits = `UART_BITS_PER_FRAME - 2;      // Minus start and stop.
  localparam int cnt_w     = $clog2(`UART_CLKS_PER_BIT);   // Bit period counter.
  localparam int bidx_w    = $clog2(data_bits);            // Data bit index.

  tx_state_t            state;       // Frame position.
  logic [cnt_w-1:0]     cnt;         // Clocks into current bit.
  logic [bidx_w-1:0]    bit_idx;     // Data bit being sent.
  logic [data_bits-1:0] shreg;       // Remaining data bits.
  logic                 eom_q;       // Frame closes a message.
  logic                 bit_end;     // Last clock of a bit.
  logic                 last_data;   // Final data bit on the line.
  logic                 shift;       // Advance shift register.

  //////////////////////////////////////////////////////////////////////
  // Timing helpers
  //////////////////////////////////////////////////////////////////////

  assign bit_end   = (cnt == cnt_w'(`UART_CLKS_PER_BIT - 1));
  assign last_data = (bit_idx == bidx_w'(data_bits - 1));
  assign shift     = bit_end && (state == TX_START || state == TX_DATA);

  assign pop      = (state == TX_IDLE) && !empty;      // Take beat when idle.
  assign msg_done = (state == TX_STOP) && bit_end && eom_q;   // Last stop clock.

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
      begin
        state   <= TX_IDLE;
        cnt     <= '0;
        bit_idx <= '0;
        txd     <= 1'b1;   // Line idles high.
      end
    else
      case (state)
        TX_IDLE :
          if (pop)
            begin
              state <= TX_START;
              cnt   <= '0;
              txd   <= 1'b0;   // Start bit next cycle.
            end
        TX_START :
          if (bit_end)
            begin
              state   <= TX_DATA;
              cnt     <= '0;
              bit_idx <= '0;
              txd     <= shreg[0];   // LSB first.
            end
          else
            cnt <= cnt + 1'b1;
        TX_DATA :
          if (bit_end)
            begin
              cnt <= '0;
              if (last_data)
                begin
                  state <= TX_STOP;
                  txd   <= 1'b1;   // Stop bit.
                end
              else
                begin
                  bit_idx <= bit_idx + 1'b1;
                  txd     <= shreg[0];   // Next data bit.
                end
            end
          else
            cnt <= cnt + 1'b1;
        TX_STOP :
          if (bit_end)
            begin
              state <= TX_IDLE;   // Pop allowed next cycle.
              cnt   <= '0;
            end
          else
            cnt <= cnt + 1'b1;
        default :
          state <= TX_IDLE;
      endcase

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  // Payload, loaded on pop.
  always_ff @(posedge clk)
    if (pop)
      begin
        shreg <= head_beat.data;
        eom_q <= head_beat.eom;
      end
    else if (shift)
      shreg <= shreg >> 1;   // Expose next bit at LSB.

  // A popped beat starts its frame on the following cycle.
  assert property (@(posedge clk) disable iff (!arst_n)
                   pop |-> (state == TX_IDLE) ##1 (state == TX_START && !txd))
    else $error("uart_tx: pop outside idle or frame not started");

endmodule

// File: verilog/byte_fifo.sv
/*
  Byte beat FIFO.
  Eight entry first-word-fall-through buffer between the message
  source and the transmitter, with full and empty flags.
*/

`timescale 1ns/10ps

`include "uart_consts.svh"

module byte_fifo (
  input  logic                clk,         // Clock.
  input  logic                arst_n,      // Async reset, active low.
  input  logic                push,        // Write strobe.
  input  uart_pkg::msg_beat_t push_beat,   // Beat to write.
  input  logic                pop,         // Read strobe.
  output uart_pkg::msg_beat_t head_beat,   // Oldest beat.
  output logic                full,        // No free slot.
  output logic                empty        // Nothing stored.
);

  import uart_pkg::*;

  localparam int aw    = `FIFO_AW;   // Address width.
  localparam int depth = 1 << aw;    // Entry count.

  //////////////////////////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////////////////////////

  msg_beat_t     mem [0:depth-1];   // Beat storage.
  logic [aw:0]   wr_ptr;            // Write pointer, extra wrap bit.
  logic [aw:0]   rd_ptr;            // Read pointer, extra wrap bit.
  logic [aw-1:0] wr_addr;           // Write slot.
  logic [aw-1:0] rd_addr;           // Read slot.
  logic          same_addr;         // Pointers on the same slot.
  logic          same_wrap;         // Pointers on the same lap.

  assign wr_addr = wr_ptr[aw-1:0];
  assign rd_addr = rd_ptr[aw-1:0];

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end
    else
      begin
        if (push)
          wr_ptr <= wr_ptr + 1'b1;   // Advance on write.
        if (pop)
          rd_ptr <= rd_ptr + 1'b1;   // Advance on read.
      end

  // Entries carry no reset.
  always_ff @(posedge clk)
    if (push)
      mem[wr_addr] <= push_beat;

  //////////////////////////////////////////////////////////////////////
  // Head and flags
  //////////////////////////////////////////////////////////////////////

  assign head_beat = mem[rd_addr];   // Fall through from read slot.

  assign same_addr = (wr_addr == rd_addr);
  assign same_wrap = (wr_ptr[aw] == rd_ptr[aw]);

  assign empty = same_addr && same_wrap;    // Caught up.
  assign full  = same_addr && !same_wrap;   // Writer a lap ahead.

  //////////////////////////////////////////////////////////////////////
  // Handshake checks
  //////////////////////////////////////////////////////////////////////

  // Source must honor the busy level.
  assert property (@(posedge clk) disable iff (!arst_n)
                   push |-> !full)
    else $error("byte_fifo: push while full");

  // Transmitter must only take a shown beat.
  assert property (@(posedge clk) disable iff (!arst_n)
                   pop |-> !empty)
    else $error("byte_fifo: pop while empty");

endmodule

// File: verilog/msg_source.sv
/*
  Message source.
  Walks a fixed character ROM and hands one character at a time
  downstream through a holding register while the FIFO is not busy.
*/

`timescale 1ns/10ps

`include "uart_consts.svh"

module msg_source (
  input  logic                clk,         // Clock.
  input  logic                arst_n,      // Async reset, active low.
  input  logic                run,         // Allow new characters.
  input  logic                busy,        // Downstream full.
  output logic                push,        // One cycle write strobe.
  output uart_pkg::msg_beat_t push_beat    // Character and eom flag.
);

  import uart_pkg::*;

  localparam int idx_w = $clog2(`MSG_LEN);   // ROM index width.

  logic [idx_w-1:0] index;       // Next ROM character.
  logic             hold_full;   // Holding register occupied.
  logic             load;        // Fetch into holding register.
  logic             last_idx;    // Index sits on the line feed.
  msg_beat_t        rom_beat;    // Beat read from ROM.

  //////////////////////////////////////////////////////////////////////
  // Character ROM
  //////////////////////////////////////////////////////////////////////

  assign last_idx = (index == idx_w'(`MSG_LEN - 1));

  always_comb
    begin
      rom_beat.eom = last_idx;   // Flag on the final character.
      case (index)
        4'd0    : rom_beat.data = "L";
        4'd1    : rom_beat.data = "o";
        4'd2    : rom_beat.data = "r";
        4'd3    : rom_beat.data = "e";
        4'd4    : rom_beat.data = "m";
        4'd5    : rom_beat.data = " ";
        4'd6    : rom_beat.data = "I";
        4'd7    : rom_beat.data = "p";
        4'd8    : rom_beat.data = "s";
        4'd9    : rom_beat.data = "u";
        4'd10   : rom_beat.data = "m";
        4'd11   : rom_beat.data = 8'h0d;   // Carriage return.
        4'd12   : rom_beat.data = 8'h0a;   // Line feed.
        default : rom_beat.data = 8'h00;   // Never reached.
      endcase
    end

  //////////////////////////////////////////////////////////////////////
  // Holding register and handoff
  //////////////////////////////////////////////////////////////////////

  assign load = !hold_full && run;   // Paused source loads nothing.

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
      begin
        hold_full <= 1'b0;
        push      <= 1'b0;
        index     <= '0;
      end
    else if (hold_full && !busy)
      begin
        push      <= 1'b1;   // Hand off next cycle.
        hold_full <= 1'b0;
      end
    else
      begin
        push <= 1'b0;
        if (load)
          begin
            hold_full <= 1'b1;
            index     <= last_idx ? '0 : index + 1'b1;   // Wrap after LF.
          end
      end

  // Payload only, written on fetch.
  always_ff @(posedge clk)
    if (load)
      push_beat <= rom_beat;

  // Handoff decided on a not busy cycle must still see room.
  assert property (@(posedge clk) disable iff (!arst_n)
                   push |-> !busy)
    else $error("msg_source: push while FIFO busy");

endmodule

// File: verilog/uart_pkg.sv
/*
  Serial message beacon types.
  Byte beat passed down the chain and transmitter FSM states.
*/

package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Beat from source through FIFO to transmitter
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       eom;    // Last character of the message.
    logic [7:0] data;   // ASCII character.
  } msg_beat_t;

  //////////////////////////////////////////////////////////////////////
  // Transmitter FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    TX_IDLE,    // Line high, waiting for a beat.
    TX_START,   // Start bit, line low.
    TX_DATA,    // Data bits, LSB first.
    TX_STOP     // Stop bit, line high.
  } tx_state_t;

endpackage

// File: verilog/uart_consts.svh
/*
  Serial message beacon constants.
  Bit timing, FIFO sizing and message length.
*/

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Serial line timing
//////////////////////////////////////////////////////////////////////

`define UART_CLKS_PER_BIT    16   // Clocks per serial bit, sim friendly.
`define UART_BITS_PER_FRAME  10   // Start, 8 data, stop.

//////////////////////////////////////////////////////////////////////
// Buffering and message
//////////////////////////////////////////////////////////////////////

`define FIFO_AW              3    // FIFO address width, 8 beats deep.
`define MSG_LEN              13   // "Lorem Ipsum" plus CR LF.

`endif
